/* hdl/execPkg.sv */
package execPkg;

    localparam int WordWidth  = 32;
    localparam int RegIdWidth = 4;
    localparam int ImmWidth   = 16;

    typedef logic [WordWidth-1:0]  word_t;     // Data word and byte address
    typedef logic [RegIdWidth-1:0] regIdx_t;
    typedef logic [ImmWidth-1:0]   imm_t;
    typedef logic [3:0]            flags_t;    // NZCV
    typedef logic [3:0]            aluOp_t;
    typedef logic [3:0]            cond_t;
    typedef logic [1:0]            instClass_t;

    // Instruction classes
    localparam instClass_t ClassImm    = 2'b00;
    localparam instClass_t ClassReg    = 2'b01;
    localparam instClass_t ClassMem    = 2'b10;
    localparam instClass_t ClassBranch = 2'b11;

    // Operation codes, bit 3 selects the flag-setting form
    localparam aluOp_t OpMov  = 4'b0000;   // Immediate class only
    localparam aluOp_t OpAdd  = 4'b0001;
    localparam aluOp_t OpSub  = 4'b0010;
    localparam aluOp_t OpAnd  = 4'b0011;
    localparam aluOp_t OpOr   = 4'b0100;
    localparam aluOp_t OpXor  = 4'b0101;
    localparam aluOp_t OpNot  = 4'b0110;   // Register class only
    localparam aluOp_t OpAdds = 4'b1001;
    localparam aluOp_t OpSubs = 4'b1010;
    localparam aluOp_t OpAnds = 4'b1011;
    localparam aluOp_t OpOrs  = 4'b1100;
    localparam aluOp_t OpXors = 4'b1101;

    // Branch conditions, 1110 and 1111 never taken
    localparam cond_t CondEq = 4'b0000;
    localparam cond_t CondNe = 4'b0001;
    localparam cond_t CondHs = 4'b0010;
    localparam cond_t CondLo = 4'b0011;
    localparam cond_t CondMi = 4'b0100;
    localparam cond_t CondPl = 4'b0101;
    localparam cond_t CondVs = 4'b0110;
    localparam cond_t CondVc = 4'b0111;
    localparam cond_t CondHi = 4'b1000;
    localparam cond_t CondLs = 4'b1001;
    localparam cond_t CondGe = 4'b1010;
    localparam cond_t CondLt = 4'b1011;
    localparam cond_t CondGt = 4'b1100;
    localparam cond_t CondLe = 4'b1101;

    // Bit positions within flags_t
    localparam int FlagN = 3;
    localparam int FlagZ = 2;
    localparam int FlagC = 1;
    localparam int FlagV = 0;

endpackage

/* hdl/aluUnit.sv */
`timescale 1ns/100ps

module aluUnit (
    input  execPkg::aluOp_t aluOp,
    input  execPkg::word_t  operandA,
    input  execPkg::word_t  operandB,
    input  execPkg::flags_t flags,
    output execPkg::word_t  result,
    output execPkg::flags_t flagsNext
);

    logic [32:0] sum;          // Bit 32 is the carry out
    logic [32:0] diff;         // Bit 32 is the borrow
    logic        addOverflow;
    logic        subOverflow;
    logic        updateNz;

    assign sum  = {1'b0, operandA} + {1'b0, operandB};
    assign diff = {1'b0, operandA} - {1'b0, operandB};

    // Same operand signs, result sign flipped
    assign addOverflow = ~(operandA[31] ^ operandB[31]) & (operandA[31] ^ sum[31]);
    // Operand signs differ and result sign left the first operand
    assign subOverflow = (operandA[31] ^ operandB[31]) & (operandA[31] ^ diff[31]);

    always_comb begin
        result    = '0;
        flagsNext = flags;     // C and V kept unless arithmetic
        updateNz  = 1'b0;
        case (aluOp)
            execPkg::OpMov: result = operandB;
            execPkg::OpNot: result = ~operandA;
            execPkg::OpAdd, execPkg::OpAdds: begin
                result                    = sum[31:0];
                flagsNext[execPkg::FlagC] = sum[32];
                flagsNext[execPkg::FlagV] = addOverflow;
                updateNz                  = 1'b1;
            end
            execPkg::OpSub, execPkg::OpSubs: begin
                result                    = diff[31:0];
                flagsNext[execPkg::FlagC] = ~diff[32];     // Carry is not-borrow
                flagsNext[execPkg::FlagV] = subOverflow;
                updateNz                  = 1'b1;
            end
            execPkg::OpAnd, execPkg::OpAnds: begin
                result   = operandA & operandB;
                updateNz = 1'b1;
            end
            execPkg::OpOr, execPkg::OpOrs: begin
                result   = operandA | operandB;
                updateNz = 1'b1;
            end
            execPkg::OpXor, execPkg::OpXors: begin
                result   = operandA ^ operandB;
                updateNz = 1'b1;
            end
            default: result = '0;      // No-op codes
        endcase
        if (updateNz) begin
            flagsNext[execPkg::FlagN] = result[31];
            flagsNext[execPkg::FlagZ] = (result == '0);
        end
    end

endmodule

/* hdl/flagUnit.sv */
`timescale 1ns/100ps

module flagUnit (
    input  logic            clk,
    input  logic            rst,
    input  logic            flagWrite,
    input  execPkg::flags_t flagsNext,
    input  execPkg::cond_t  cond,
    output execPkg::flags_t flags,
    output logic            condMet
);

    logic n;
    logic z;
    logic c;
    logic v;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags <= '0;
        end else if (flagWrite) begin
            flags <= flagsNext;
        end
    end

    assign n = flags[execPkg::FlagN];
    assign z = flags[execPkg::FlagZ];
    assign c = flags[execPkg::FlagC];
    assign v = flags[execPkg::FlagV];

    // Evaluated on the held flags, so a branch sees the state before its own edge
    always_comb begin
        case (cond)
            execPkg::CondEq: condMet = z;
            execPkg::CondNe: condMet = ~z;
            execPkg::CondHs: condMet = c;
            execPkg::CondLo: condMet = ~c;
            execPkg::CondMi: condMet = n;
            execPkg::CondPl: condMet = ~n;
            execPkg::CondVs: condMet = v;
            execPkg::CondVc: condMet = ~v;
            execPkg::CondHi: condMet = c & ~z;         // Unsigned higher
            execPkg::CondLs: condMet = ~(c & ~z);
            execPkg::CondGe: condMet = (n == v);       // Signed compares
            execPkg::CondLt: condMet = (n != v);
            execPkg::CondGt: condMet = ~z & (n == v);
            execPkg::CondLe: condMet = z | (n != v);
            default:         condMet = 1'b0;
        endcase
    end

endmodule

/* hdl/memAccess.sv */
`timescale 1ns/100ps

module memAccess (
    input  logic           clk,
    input  logic           rst,
    input  logic           reqValid,
    input  logic           reqStore,
    input  execPkg::word_t reqAddr,
    input  execPkg::word_t reqData,
    input  execPkg::word_t wbDatIn,
    input  logic           wbAck,
    output logic           busy,
    output logic           loadDone,
    output execPkg::word_t loadData,
    output logic           wbCyc,
    output logic           wbStb,
    output logic           wbWe,
    output execPkg::word_t wbAdr,
    output execPkg::word_t wbDatOut
);

    typedef enum logic {
        WbIdle,
        WbActive
    } wbState_t;

    wbState_t       state;
    logic           storeQ;
    execPkg::word_t addrQ;
    execPkg::word_t dataQ;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= WbIdle;
            storeQ   <= 1'b0;
            loadDone <= 1'b0;
        end else begin
            loadDone <= 1'b0;
            case (state)
                WbIdle: begin
                    if (reqValid) begin
                        state  <= WbActive;
                        storeQ <= reqStore;
                    end
                end
                WbActive: begin
                    if (wbAck) begin
                        state    <= WbIdle;
                        loadDone <= ~storeQ;   // Pulse only for loads
                    end
                end
                default: state <= WbIdle;
            endcase
        end
    end

    // Request buffer, held stable for the whole bus cycle
    always_ff @(posedge clk) begin
        if (state == WbIdle && reqValid) begin
            addrQ <= reqAddr;
            dataQ <= reqData;
        end
        if (state == WbActive && wbAck && !storeQ) begin
            loadData <= wbDatIn;
        end
    end

    assign busy     = (state == WbActive);
    assign wbCyc    = (state == WbActive);
    assign wbStb    = (state == WbActive);     // Classic cycle, stb follows cyc
    assign wbWe     = (state == WbActive) & storeQ;
    assign wbAdr    = addrQ;
    assign wbDatOut = dataQ;

endmodule

/* hdl/execControl.sv */
`timescale 1ns/100ps

module execControl (
    input  logic                clk,
    input  logic                rst,
    input  logic                instValid,
    input  execPkg::instClass_t instClass,
    input  execPkg::aluOp_t     aluOp,
    input  logic                isStore,
    input  execPkg::regIdx_t    destReg,
    input  execPkg::regIdx_t    firstReg,
    input  execPkg::regIdx_t    secReg,
    input  execPkg::imm_t       imm,
    input  execPkg::word_t      readDataDest,
    input  execPkg::word_t      readDataFirst,
    input  execPkg::word_t      readDataSec,
    input  execPkg::word_t      aluResult,
    input  logic                condMet,
    input  logic                busy,
    input  logic                loadDone,
    input  execPkg::word_t      loadData,
    output logic                instReady,
    output execPkg::regIdx_t    readRegDest,
    output execPkg::regIdx_t    readRegFirst,
    output execPkg::regIdx_t    readRegSec,
    output execPkg::word_t      operandA,
    output execPkg::word_t      operandB,
    output logic                flagWrite,
    output logic                reqValid,
    output logic                reqStore,
    output execPkg::word_t      reqAddr,
    output execPkg::word_t      reqData,
    output logic                writeToReg,
    output execPkg::regIdx_t    writeReg,
    output execPkg::word_t      writeData,
    output logic                branchTaken
);

    logic             accept;
    logic             isAlu;
    logic             legalOp;
    logic             aluWrite;
    logic             aluWriteQ;
    execPkg::word_t   immSext;
    execPkg::word_t   resultQ;
    execPkg::regIdx_t destQ;

    assign instReady = ~busy;          // One memory access in flight at most
    assign accept    = instValid & instReady;
    assign isAlu     = (instClass == execPkg::ClassImm) || (instClass == execPkg::ClassReg);
    assign immSext   = {{16{imm[15]}}, imm};

    // MOV and NOT are each legal in one class only
    always_comb begin
        case (aluOp)
            execPkg::OpMov: legalOp = (instClass == execPkg::ClassImm);
            execPkg::OpNot: legalOp = (instClass == execPkg::ClassReg);
            execPkg::OpAdd, execPkg::OpSub, execPkg::OpAnd, execPkg::OpOr,
            execPkg::OpXor, execPkg::OpAdds, execPkg::OpSubs, execPkg::OpAnds,
            execPkg::OpOrs, execPkg::OpXors: legalOp = 1'b1;
            default: legalOp = 1'b0;
        endcase
    end

    assign aluWrite  = accept & isAlu & legalOp;
    assign flagWrite = aluWrite & aluOp[3];

    // Register file reads
    assign readRegFirst = firstReg;
    assign readRegSec   = (instClass == execPkg::ClassReg) ? secReg : '0;
    assign readRegDest  = (instClass == execPkg::ClassMem && isStore) ? destReg : '0;

    assign operandA = readDataFirst;
    always_comb begin
        if (instClass == execPkg::ClassReg) begin
            operandB = readDataSec;
        end else if (aluOp == execPkg::OpMov) begin
            operandB = {16'h0000, imm};    // Upper half cleared
        end else begin
            operandB = immSext;
        end
    end

    // Memory request launched at the accepting edge
    assign reqValid = accept & (instClass == execPkg::ClassMem);
    assign reqStore = isStore;
    assign reqAddr  = readDataFirst + immSext;
    assign reqData  = readDataDest;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            aluWriteQ   <= 1'b0;
            branchTaken <= 1'b0;
        end else begin
            aluWriteQ   <= aluWrite;
            branchTaken <= accept & (instClass == execPkg::ClassBranch) & condMet;
        end
    end

    // Destination stays put while a load is on the bus
    always_ff @(posedge clk) begin
        if (accept) begin
            destQ   <= destReg;
            resultQ <= aluResult;
        end
    end

    assign writeToReg = aluWriteQ | loadDone;
    assign writeReg   = destQ;
    assign writeData  = loadDone ? loadData : resultQ;

endmodule

/* hdl/execTop.sv */
`timescale 1ns/100ps

module execTop (
    input  logic                clk,
    input  logic                rst,
    input  logic                instValid,
    input  execPkg::instClass_t instClass,
    input  execPkg::aluOp_t     aluOp,
    input  execPkg::cond_t      cond,
    input  logic                isStore,
    input  execPkg::regIdx_t    destReg,
    input  execPkg::regIdx_t    firstReg,
    input  execPkg::regIdx_t    secReg,
    input  execPkg::imm_t       imm,
    output logic                instReady,
    output execPkg::regIdx_t    readRegDest,
    output execPkg::regIdx_t    readRegFirst,
    output execPkg::regIdx_t    readRegSec,
    input  execPkg::word_t      readDataDest,
    input  execPkg::word_t      readDataFirst,
    input  execPkg::word_t      readDataSec,
    output logic                writeToReg,
    output execPkg::regIdx_t    writeReg,
    output execPkg::word_t      writeData,
    output logic                branchTaken,
    output execPkg::flags_t     flagsOut,
    output logic                wbCyc,
    output logic                wbStb,
    output logic                wbWe,
    output execPkg::word_t      wbAdr,
    output execPkg::word_t      wbDatOut,
    input  execPkg::word_t      wbDatIn,
    input  logic                wbAck
);

    execPkg::word_t  operandA;
    execPkg::word_t  operandB;
    execPkg::word_t  aluResult;
    execPkg::flags_t flagsNext;
    logic            flagWrite;
    logic            condMet;
    logic            reqValid;
    logic            reqStore;
    execPkg::word_t  reqAddr;
    execPkg::word_t  reqData;
    logic            busy;
    logic            loadDone;
    execPkg::word_t  loadData;

    execControl control (
        .clk(clk), .rst(rst),
        .instValid(instValid), .instClass(instClass), .aluOp(aluOp),
        .isStore(isStore), .destReg(destReg), .firstReg(firstReg),
        .secReg(secReg), .imm(imm),
        .readDataDest(readDataDest), .readDataFirst(readDataFirst),
        .readDataSec(readDataSec), .aluResult(aluResult), .condMet(condMet),
        .busy(busy), .loadDone(loadDone), .loadData(loadData),
        .instReady(instReady), .readRegDest(readRegDest),
        .readRegFirst(readRegFirst), .readRegSec(readRegSec),
        .operandA(operandA), .operandB(operandB), .flagWrite(flagWrite),
        .reqValid(reqValid), .reqStore(reqStore), .reqAddr(reqAddr),
        .reqData(reqData), .writeToReg(writeToReg), .writeReg(writeReg),
        .writeData(writeData), .branchTaken(branchTaken)
    );

    aluUnit alu (
        .aluOp(aluOp), .operandA(operandA), .operandB(operandB),
        .flags(flagsOut), .result(aluResult), .flagsNext(flagsNext)
    );

    flagUnit flagReg (
        .clk(clk), .rst(rst), .flagWrite(flagWrite), .flagsNext(flagsNext),
        .cond(cond), .flags(flagsOut), .condMet(condMet)
    );

    memAccess mem (
        .clk(clk), .rst(rst),
        .reqValid(reqValid), .reqStore(reqStore), .reqAddr(reqAddr),
        .reqData(reqData), .wbDatIn(wbDatIn), .wbAck(wbAck),
        .busy(busy), .loadDone(loadDone), .loadData(loadData),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbDatOut(wbDatOut)
    );

endmodule

/* testbench/wbMemModel.sv */
`timescale 1ns/100ps

module wbMemModel (
    input  logic           clk,
    input  logic           rst,
    input  logic           cyc,
    input  logic           stb,
    input  logic           we,
    input  execPkg::word_t adr,
    input  execPkg::word_t writeData,
    output execPkg::word_t readData,
    output logic           ack
);

    execPkg::word_t mem [0:255];
    integer         seed;
    int             waitLeft;
    int             delay;
    logic           counting;

    initial begin
        seed = 32'h2ab1;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h5a00_0000 ^ (i << 2) ^ (i << 18);   // Word address folded in twice
        end
    end

    // Registered ack after 0 to 3 wait cycles, held for one cycle only
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            ack      <= 1'b0;
            counting <= 1'b0;
            readData <= '0;
        end else if (ack) begin
            ack      <= 1'b0;
            counting <= 1'b0;
        end else if (cyc && stb) begin
            if (!counting) begin
                delay = $unsigned($random(seed)) % 4;
                counting <= 1'b1;
            end else begin
                delay = waitLeft;
            end
            if (delay == 0) begin
                ack      <= 1'b1;
                readData <= mem[adr[9:2]];
                if (we) begin
                    mem[adr[9:2]] <= writeData;
                end
            end else begin
                waitLeft <= delay - 1;
            end
        end
    end

endmodule

/* testbench/execTb.sv */
`timescale 1ns/100ps

module execTb;

    localparam int ClkPeriod    = 20;
    localparam int NumRandom    = 150;
    localparam int NumPairs     = 6;
    localparam int TotalInsts   = NumRandom + 10 + 16 * NumPairs * 2 + 4;
    localparam int WatchdogTime = (TotalInsts * 10 + 100) * ClkPeriod;

    logic                clk;
    logic                rst;
    logic                instValid;
    execPkg::instClass_t instClass;
    execPkg::aluOp_t     aluOp;
    execPkg::cond_t      cond;
    logic                isStore;
    execPkg::regIdx_t    destReg;
    execPkg::regIdx_t    firstReg;
    execPkg::regIdx_t    secReg;
    execPkg::imm_t       imm;
    logic                instReady;
    execPkg::regIdx_t    readRegDest;
    execPkg::regIdx_t    readRegFirst;
    execPkg::regIdx_t    readRegSec;
    execPkg::word_t      readDataDest;
    execPkg::word_t      readDataFirst;
    execPkg::word_t      readDataSec;
    logic                writeToReg;
    execPkg::regIdx_t    writeReg;
    execPkg::word_t      writeData;
    logic                branchTaken;
    execPkg::flags_t     flagsOut;
    logic                wbCyc;
    logic                wbStb;
    logic                wbWe;
    execPkg::word_t      wbAdr;
    execPkg::word_t      wbDatOut;
    execPkg::word_t      wbDatIn;
    logic                wbAck;

    execPkg::word_t  regFile [0:15];
    execPkg::flags_t expFlags;      // Flags the DUT should hold
    execPkg::word_t  lastStoreData;
    execPkg::word_t  pairA [0:NumPairs-1];
    execPkg::word_t  pairB [0:NumPairs-1];
    integer          seed;
    int              errors;
    int              testStartErrors;
    int              passCount;
    int              failCount;

    execTop DUT (
        .clk(clk), .rst(rst),
        .instValid(instValid), .instClass(instClass), .aluOp(aluOp), .cond(cond),
        .isStore(isStore), .destReg(destReg), .firstReg(firstReg), .secReg(secReg),
        .imm(imm), .instReady(instReady),
        .readRegDest(readRegDest), .readRegFirst(readRegFirst), .readRegSec(readRegSec),
        .readDataDest(readDataDest), .readDataFirst(readDataFirst),
        .readDataSec(readDataSec),
        .writeToReg(writeToReg), .writeReg(writeReg), .writeData(writeData),
        .branchTaken(branchTaken), .flagsOut(flagsOut),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatOut(wbDatOut), .wbDatIn(wbDatIn), .wbAck(wbAck)
    );

    wbMemModel memory (
        .clk(clk), .rst(rst), .cyc(wbCyc), .stb(wbStb), .we(wbWe),
        .adr(wbAdr), .writeData(wbDatOut), .readData(wbDatIn), .ack(wbAck)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // Register file model, combinational reads
    assign readDataDest  = regFile[readRegDest];
    assign readDataFirst = regFile[readRegFirst];
    assign readDataSec   = regFile[readRegSec];

    always @(posedge clk) begin
        if (writeToReg) begin
            regFile[writeReg] <= writeData;
        end
    end

    initial begin
        #(WatchdogTime);
        $display("Timeout: the run did not finish in the expected time");
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic reportFailure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic finishTest(input string name);
        if (errors == testStartErrors) begin
            passCount++;
        end else begin
            failCount++;
        end
        $display("Test %s finished with %0d errors", name, errors - testStartErrors);
        testStartErrors = errors;
    endtask

    task automatic setReg(input execPkg::regIdx_t idx, input execPkg::word_t value);
        regFile[idx] = value;
    endtask

    // Expected ALU behavior straight from the operation rules
    task automatic predictAlu(input execPkg::instClass_t cls, input execPkg::aluOp_t op,
                              input execPkg::word_t a, input execPkg::word_t b,
                              output logic legal, output execPkg::word_t res,
                              output execPkg::flags_t nf);
        legal = 1'b1;
        res   = '0;
        nf    = expFlags;
        case (op)
            execPkg::OpMov: begin
                legal = (cls == execPkg::ClassImm);
                res   = b;
            end
            execPkg::OpNot: begin
                legal = (cls == execPkg::ClassReg);
                res   = ~a;
            end
            execPkg::OpAdd, execPkg::OpAdds: res = a + b;
            execPkg::OpSub, execPkg::OpSubs: res = a - b;
            execPkg::OpAnd, execPkg::OpAnds: res = a & b;
            execPkg::OpOr, execPkg::OpOrs:   res = a | b;
            execPkg::OpXor, execPkg::OpXors: res = a ^ b;
            default: legal = 1'b0;
        endcase
        if (legal && op[3]) begin
            nf[execPkg::FlagN] = res[31];
            nf[execPkg::FlagZ] = (res == 32'h0);
            if (op == execPkg::OpAdds) begin
                nf[execPkg::FlagC] = (res < a);    // Unsigned wrap means carry out
                nf[execPkg::FlagV] = (a[31] == b[31]) && (res[31] != a[31]);
            end
            if (op == execPkg::OpSubs) begin
                nf[execPkg::FlagC] = (a >= b);     // No borrow
                nf[execPkg::FlagV] = (a[31] != b[31]) && (res[31] != a[31]);
            end
        end
    endtask

    function automatic logic condHolds(input execPkg::flags_t fl, input execPkg::cond_t c);
        logic n;
        logic z;
        logic cf;
        logic v;
        n  = fl[execPkg::FlagN];
        z  = fl[execPkg::FlagZ];
        cf = fl[execPkg::FlagC];
        v  = fl[execPkg::FlagV];
        case (c)
            4'd0:    return z;
            4'd1:    return !z;
            4'd2:    return cf;
            4'd3:    return !cf;
            4'd4:    return n;
            4'd5:    return !n;
            4'd6:    return v;
            4'd7:    return !v;
            4'd8:    return cf && !z;
            4'd9:    return !cf || z;
            4'd10:   return n == v;
            4'd11:   return n != v;
            4'd12:   return !z && (n == v);
            4'd13:   return z || (n != v);
            default: return 1'b0;
        endcase
    endfunction

    // Called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic issueInst(input execPkg::instClass_t cls, input execPkg::aluOp_t op,
                             input execPkg::cond_t c, input logic st,
                             input execPkg::regIdx_t d, input execPkg::regIdx_t f,
                             input execPkg::regIdx_t s, input execPkg::imm_t im);
        logic acc;
        instValid = 1'b1;
        instClass = cls;
        aluOp     = op;
        cond      = c;
        isStore   = st;
        destReg   = d;
        firstReg  = f;
        secReg    = s;
        imm       = im;
        acc       = 1'b0;
        while (!acc) begin
            acc = instReady;
            @(posedge clk);
            #1;
        end
        instValid = 1'b0;
    endtask

    task automatic runAlu(input execPkg::instClass_t cls, input execPkg::aluOp_t op,
                          input execPkg::regIdx_t d, input execPkg::regIdx_t f,
                          input execPkg::regIdx_t s, input execPkg::imm_t im);
        execPkg::word_t  b;
        execPkg::word_t  res;
        execPkg::flags_t nf;
        logic            legal;
        if (cls == execPkg::ClassReg) begin
            b = regFile[s];
        end else if (op == execPkg::OpMov) begin
            b = {16'h0000, im};
        end else begin
            b = {{16{im[15]}}, im};
        end
        predictAlu(cls, op, regFile[f], b, legal, res, nf);
        issueInst(cls, op, 4'd0, 1'b0, d, f, s, im);
        @(negedge clk);
        checkValue("writeToReg", legal, writeToReg);
        if (legal) begin
            checkValue("writeReg", d, writeReg);
            checkValue("writeData", res, writeData);
        end
        checkValue("flagsOut", nf, flagsOut);
        checkValue("branchTaken", 0, branchTaken);
        expFlags = nf;
        @(posedge clk);
        #1;
    endtask

    task automatic runBranch(input execPkg::cond_t c);
        logic taken;
        taken = condHolds(expFlags, c);
        issueInst(execPkg::ClassBranch, 4'd0, c, 1'b0, 4'd0, 4'd0, 4'd0, 16'h0);
        @(negedge clk);
        checkValue("branchTaken", taken, branchTaken);
        checkValue("writeToReg", 0, writeToReg);
        checkValue("flagsOut", expFlags, flagsOut);
        @(posedge clk);
        #1;
    endtask

    task automatic runMem(input logic st, input execPkg::regIdx_t d,
                          input execPkg::regIdx_t f, input execPkg::imm_t im);
        execPkg::word_t expAddr;
        logic           ackSeen;
        logic           done;
        expAddr = regFile[f] + {{16{im[15]}}, im};
        if (st) begin
            lastStoreData = regFile[d];
        end
        issueInst(execPkg::ClassMem, 4'd0, 4'd0, st, d, f, 4'd0, im);
        @(negedge clk);
        assert (wbCyc && wbStb) else reportFailure("Bus cycle did not start after acceptance");
        ackSeen = 1'b0;
        done    = 1'b0;
        while (!done) begin
            if (ackSeen) begin
                assert (!wbCyc && !wbStb) else reportFailure("cyc or stb still high after ack");
                checkValue("instReady", 1, instReady);
                checkValue("writeToReg", !st, writeToReg);
                if (!st) begin
                    checkValue("writeReg", d, writeReg);
                    checkValue("writeData", lastStoreData, writeData);
                end
                done = 1'b1;
            end else begin
                assert (wbCyc && wbStb) else reportFailure("cyc or stb dropped before ack");
                checkValue("wbAdr", expAddr, wbAdr);
                checkValue("wbWe", st, wbWe);
                if (st) begin
                    checkValue("wbDatOut", lastStoreData, wbDatOut);
                end
                checkValue("instReady", 0, instReady);
                checkValue("writeToReg", 0, writeToReg);
                ackSeen = wbAck;
                @(negedge clk);
            end
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        instValid = 1'b0;
        instClass = '0;
        aluOp     = '0;
        cond      = '0;
        isStore   = 1'b0;
        destReg   = '0;
        firstReg  = '0;
        secReg    = '0;
        imm       = '0;
        seed      = 32'h2ab1;
        errors    = 0;
        passCount = 0;
        failCount = 0;
        testStartErrors = 0;
        expFlags  = '0;
        for (int i = 0; i < 16; i++) begin
            regFile[i] = 32'h0101_0101 * i ^ 32'h8000_0000 * (i % 2);
        end
        pairA[0] = 32'h0000_0000;   // Z and C
        pairB[0] = 32'h0000_0000;
        pairA[1] = 32'h0000_0001;   // Borrow
        pairB[1] = 32'h0000_0002;
        pairA[2] = 32'h0000_0002;
        pairB[2] = 32'h0000_0001;
        pairA[3] = 32'h8000_0000;   // Overflow to positive
        pairB[3] = 32'h0000_0001;
        pairA[4] = 32'h7fff_ffff;   // Overflow to negative
        pairB[4] = 32'hffff_ffff;
        pairA[5] = 32'hffff_ffff;
        pairB[5] = 32'h0000_0001;

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        @(negedge clk);
        checkValue("instReady", 1, instReady);
        checkValue("writeToReg", 0, writeToReg);
        checkValue("branchTaken", 0, branchTaken);
        checkValue("wbCyc", 0, wbCyc);
        checkValue("flagsOut", 0, flagsOut);
        @(posedge clk);
        #1;
        finishTest("reset state");

        // Random ops, no-op codes and class-illegal MOV or NOT included
        for (int i = 0; i < NumRandom; i++) begin
            runAlu(($random(seed) & 1) ? execPkg::ClassReg : execPkg::ClassImm,
                   $random(seed), $random(seed), $random(seed), $random(seed),
                   $random(seed));
        end
        finishTest("random ALU operations");

        setReg(4'd1, 32'h7fff_ffff);
        setReg(4'd2, 32'h0000_0001);
        runAlu(execPkg::ClassReg, execPkg::OpAdds, 4'd3, 4'd1, 4'd2, 16'h0);
        runAlu(execPkg::ClassReg, execPkg::OpAnds, 4'd4, 4'd1, 4'd2, 16'h0);
        runAlu(execPkg::ClassReg, execPkg::OpAdd, 4'd5, 4'd2, 4'd2, 16'h0);
        runAlu(execPkg::ClassImm, execPkg::OpSubs, 4'd6, 4'd2, 4'd0, 16'h0001);
        runAlu(execPkg::ClassImm, execPkg::OpXors, 4'd7, 4'd1, 4'd0, 16'hffff);
        runAlu(execPkg::ClassImm, execPkg::OpSubs, 4'd8, 4'd2, 4'd0, 16'h0002);
        runAlu(execPkg::ClassReg, execPkg::OpOrs, 4'd9, 4'd2, 4'd2, 16'h0);
        runAlu(execPkg::ClassReg, execPkg::OpNot, 4'd10, 4'd2, 4'd0, 16'h0);
        runAlu(execPkg::ClassImm, execPkg::OpMov, 4'd11, 4'd0, 4'd0, 16'h8001);
        runAlu(execPkg::ClassImm, execPkg::OpSub, 4'd12, 4'd2, 4'd0, 16'h0005);
        finishTest("flag updates");

        for (int c = 0; c < 16; c++) begin
            for (int k = 0; k < NumPairs; k++) begin
                setReg(4'd1, pairA[k]);
                setReg(4'd2, pairB[k]);
                runAlu(execPkg::ClassReg, execPkg::OpSubs, 4'd3, 4'd1, 4'd2, 16'h0);
                runBranch(c);
            end
        end
        finishTest("branch conditions");

        setReg(4'd3, 32'h0000_0040);
        setReg(4'd5, 32'hcafe_f00d);
        runMem(1'b1, 4'd5, 4'd3, 16'hfffc);    // Negative offset
        runMem(1'b0, 4'd6, 4'd3, 16'hfffc);
        setReg(4'd7, 32'h1234_5678);
        runMem(1'b1, 4'd7, 4'd3, 16'h0010);
        runMem(1'b0, 4'd8, 4'd3, 16'h0010);
        finishTest("store and load");

        $display("Tests passed %0d, failed %0d, errors %0d", passCount, failCount, errors);
        if (failCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
hdl/execPkg.sv
hdl/aluUnit.sv
hdl/flagUnit.sv
hdl/memAccess.sv
hdl/execControl.sv
hdl/execTop.sv
testbench/wbMemModel.sv
testbench/execTb.sv
